/* include/fetch_config.svh */
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// first address fetched after reset
`define FETCH_RESET_PC 64'h0000_0000_8000_0000

// number of cache lines, must be a power of two
`define ICACHE_LINES 16

// 64-bit axi beats per line, must be a power of two
`define ICACHE_BEATS 2

// index bits select one line
`define ICACHE_INDEX_W $clog2(`ICACHE_LINES)

// beat bits select one beat inside a line
`define ICACHE_BEAT_W $clog2(`ICACHE_BEATS)

// byte offset inside a line, 8 bytes per beat
`define ICACHE_OFFSET_W (`ICACHE_BEAT_W + 3)

// whatever is left of the 64-bit address becomes the tag
`define ICACHE_TAG_W (64 - `ICACHE_INDEX_W - `ICACHE_OFFSET_W)

`endif

/* verilog/fetch_pkg.sv */
`include "fetch_config.svh"

package fetch_pkg;

   // byte address as seen by fetch and decode
   typedef logic [63:0] addr_t;

   // one rv64 instruction word, no compressed forms
   typedef logic [31:0] inst_t;

   // one axi read beat
   // holds two instructions, the lower address in the low half
   typedef logic [63:0] beat_t;

   // address bits above index and offset
   typedef logic [`ICACHE_TAG_W-1:0] tag_t;

   // refill fsm of the instruction cache
   // idle    waits for a miss
   // request holds arvalid until arready
   // refill  takes beats until rlast
   typedef enum logic [1:0] {
      idle,
      request,
      refill
   } icache_state_t;

endpackage

/* verilog/branch_predictor.sv */
module branch_predictor import fetch_pkg::*; (
   input  addr_t pc,
   input  inst_t inst,
   input  logic  hit,
   output logic  taken,
   output addr_t target
);

   // rv64 major opcodes that have a pc relative target
   localparam logic [6:0] op_jal    = 7'b1101111;
   localparam logic [6:0] op_branch = 7'b1100011;

   logic  is_jal;
   logic  is_branch;
   addr_t imm_j;
   addr_t imm_b;

   // only decode a word that really came out of the cache
   assign is_jal    = hit && (inst[6:0] == op_jal);
   assign is_branch = hit && (inst[6:0] == op_branch);

   // j-type immediate, 21 bits sign extended
   assign imm_j = {{43{inst[31]}},
                   inst[31],
                   inst[19:12],
                   inst[20],
                   inst[30:21],
                   1'b0};

   // b-type immediate, 13 bits sign extended
   assign imm_b = {{51{inst[31]}},
                   inst[31],
                   inst[7],
                   inst[30:25],
                   inst[11:8],
                   1'b0};

   // static rule
   // jal always jumps
   // backward branches (negative offset) are taken, forward ones fall through
   // jalr is not predicted since its target needs a register
   assign taken = is_jal || (is_branch && inst[31]);

   // the adder runs for both cases, taken decides if pc_gen uses it
   assign target = pc + (is_jal ? imm_j : imm_b);

endmodule

/* verilog/pc_gen.sv */
`include "fetch_config.svh"

module pc_gen import fetch_pkg::*; (
   input  logic  clk,
   input  logic  rst,
   input  logic  advance,
   input  logic  redirect,
   input  addr_t redirect_pc,
   input  logic  taken,
   input  addr_t target,
   output addr_t pc
);

   addr_t pc_seq;
   addr_t pc_next;

   // sequential successor, only 32-bit instructions
   assign pc_seq = pc + 64'd4;

   // next pc by priority
   // a redirect from a later stage beats everything
   // then a transfer to decode, which follows the predictor
   // otherwise the pc holds, covering misses and back-pressure
   always_comb begin
      pc_next = pc;
      if (redirect) begin
         pc_next = redirect_pc;
      end else if (advance) begin
         if (taken) begin
            pc_next = target;
         end else begin
            pc_next = pc_seq;
         end
      end
   end

   // pc register, starts at the reset vector
   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= `FETCH_RESET_PC;
      end else begin
         pc <= pc_next;
      end
   end

   // the load moves at the same edge as the transfer
   // so decode sees the new pc right in the next cycle

endmodule

/* verilog/icache.sv */
`include "fetch_config.svh"

module icache import fetch_pkg::*; (
   input  logic        clk,
   input  logic        rst,

   // lookup from pc_gen
   input  addr_t       pc,
   output logic        hit,
   output inst_t       inst,

   // store snoop
   input  logic        inv_en,
   input  addr_t       inv_addr,

   // axi read channel towards memory
   output logic [31:0] araddr,
   output logic [7:0]  arlen,
   output logic [2:0]  arsize,
   output logic [1:0]  arburst,
   output logic        arvalid,
   input  logic        arready,
   input  beat_t       rdata,
   input  logic [1:0]  rresp,
   input  logic        rlast,
   input  logic        rvalid,
   output logic        rready
);

   localparam int lines    = `ICACHE_LINES;
   localparam int beats    = `ICACHE_BEATS;
   localparam int index_w  = `ICACHE_INDEX_W;
   localparam int beat_w   = `ICACHE_BEAT_W;
   localparam int offset_w = `ICACHE_OFFSET_W;
   localparam int tag_w    = `ICACHE_TAG_W;

   // tag, data and valid arrays
   tag_t  tag_q [lines];
   beat_t data_q [lines][beats];
   logic [lines-1:0] valid_q;

   icache_state_t state;

   // line aligned address of the refill in flight
   logic [31:0] araddr_q;
   logic [beat_w-1:0] beat_cnt;
   // a snoop hit the line while it was being refilled
   logic inv_pending;

   logic [index_w-1:0] pc_index;
   logic [beat_w-1:0]  pc_beat;
   tag_t               pc_tag;
   logic [index_w-1:0] inv_index;
   logic [index_w-1:0] refill_index;
   logic               miss_start;
   logic               beat_take;
   beat_t              rd_beat;

   // split the fetch address
   assign pc_index = pc[offset_w +: index_w];
   assign pc_beat  = pc[3 +: beat_w];
   assign pc_tag   = pc[63 -: tag_w];

   assign inv_index    = inv_addr[offset_w +: index_w];
   assign refill_index = araddr_q[offset_w +: index_w];

   // lookup is fully combinational
   assign hit     = valid_q[pc_index] && (tag_q[pc_index] == pc_tag);
   assign rd_beat = data_q[pc_index][pc_beat];
   // bit 2 picks the instruction inside the 8-byte beat
   assign inst    = pc[2] ? rd_beat[63:32] : rd_beat[31:0];

   // a miss is only acted on when no refill is busy
   assign miss_start = (state == idle) && !hit;
   // rready is high for the whole refill, so rvalid alone takes a beat
   assign beat_take  = (state == refill) && rvalid;

   // fixed burst shape, one whole line in 8-byte beats
   assign araddr  = araddr_q;
   assign arlen   = 8'(beats - 1);
   assign arsize  = 3'd3;
   assign arburst = 2'b01;
   assign arvalid = (state == request);
   assign rready  = (state == refill);

   // rresp is not looked at, memory is taken as error free

   // refill fsm and valid bits
   always_ff @(posedge clk) begin
      if (rst) begin
         state       <= idle;
         valid_q     <= '0;
         beat_cnt    <= '0;
         inv_pending <= 1'b0;
      end else begin
         case (state)
            idle: begin
               if (!hit) begin
                  // the victim goes invalid at once, its data is about to change
                  state             <= request;
                  valid_q[pc_index] <= 1'b0;
                  inv_pending       <= 1'b0;
               end
            end
            request: begin
               // address and arvalid stay put until the slave accepts
               if (arready) begin
                  state    <= refill;
                  beat_cnt <= '0;
               end
            end
            refill: begin
               if (rvalid) begin
                  beat_cnt <= beat_cnt + 1'b1;
                  if (rlast) begin
                     state                 <= idle;
                     // a snoop seen during the burst keeps the line out
                     valid_q[refill_index] <= !inv_pending;
                  end
               end
            end
            default: begin
               state <= idle;
            end
         endcase

         // remember a snoop to the line under refill
         if ((state != idle) && inv_en && (inv_index == refill_index)) begin
            inv_pending <= 1'b1;
         end

         // snoop comes last so it wins over a fill in the same cycle
         if (inv_en) begin
            valid_q[inv_index] <= 1'b0;
         end
      end
   end

   // tag, refill address and line data
   always_ff @(posedge clk) begin
      if (miss_start) begin
         // tag is written early, the cleared valid bit hides it until the fill
         tag_q[pc_index] <= pc_tag;
         araddr_q        <= {pc[31:offset_w], {offset_w{1'b0}}};
      end
      if (beat_take) begin
         // beats arrive in address order for an incr burst
         data_q[refill_index][beat_cnt] <= rdata;
      end
   end

endmodule

/* verilog/fetch_unit.sv */
module fetch_unit import fetch_pkg::*; (
   input  logic        clk,
   input  logic        rst,

   // towards decode
   output logic        valid,
   input  logic        ready,
   output addr_t       pc,
   output inst_t       inst,

   // from later stages
   input  logic        redirect,
   input  addr_t       redirect_pc,
   input  logic        inv_en,
   input  addr_t       inv_addr,

   // axi read towards memory
   output logic [31:0] araddr,
   output logic [7:0]  arlen,
   output logic [2:0]  arsize,
   output logic [1:0]  arburst,
   output logic        arvalid,
   input  logic        arready,
   input  beat_t       rdata,
   input  logic [1:0]  rresp,
   input  logic        rlast,
   input  logic        rvalid,
   output logic        rready
);

   logic  hit;
   logic  taken;
   logic  advance;
   addr_t target;

   // an instruction is offered as soon as the cache hits
   // a redirect in the same cycle kills it, the pc is stale
   assign valid   = hit && !redirect;
   assign advance = valid && ready;

   pc_gen pc_gen_i (
      .clk         (clk),
      .rst         (rst),
      .advance     (advance),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .taken       (taken),
      .target      (target),
      .pc          (pc)
   );

   branch_predictor branch_predictor_i (
      .pc     (pc),
      .inst   (inst),
      .hit    (hit),
      .taken  (taken),
      .target (target)
   );

   icache icache_i (
      .clk      (clk),
      .rst      (rst),
      .pc       (pc),
      .hit      (hit),
      .inst     (inst),
      .inv_en   (inv_en),
      .inv_addr (inv_addr),
      .araddr   (araddr),
      .arlen    (arlen),
      .arsize   (arsize),
      .arburst  (arburst),
      .arvalid  (arvalid),
      .arready  (arready),
      .rdata    (rdata),
      .rresp    (rresp),
      .rlast    (rlast),
      .rvalid   (rvalid),
      .rready   (rready)
   );

endmodule

/* testbench/fetch_unit_asserts.sv */
`include "fetch_config.svh"

module fetch_unit_asserts import fetch_pkg::*; (
   input logic          clk,
   input logic          rst,
   input logic          valid,
   input logic          ready,
   input addr_t         pc,
   input inst_t         inst,
   input logic [31:0]   araddr,
   input logic [7:0]    arlen,
   input logic [2:0]    arsize,
   input logic [1:0]    arburst,
   input logic          arvalid,
   input logic          arready,
   input logic          rready,
   input icache_state_t state
);
   timeunit 1ns;
   timeprecision 1ps;

   // request holds with the same address until the slave takes it
   ar_hold: assert property (@(posedge clk) disable iff (rst)
      arvalid && !arready |=> arvalid && $stable(araddr))
      else $error("arvalid dropped or araddr moved before arready");

   // one whole line as an incr burst of 8-byte beats
   ar_shape: assert property (@(posedge clk) disable iff (rst)
      arvalid |-> arlen == 8'(`ICACHE_BEATS - 1) && arsize == 3'd3 && arburst == 2'b01)
      else $error("burst length, size or type is wrong");

   // refill address starts on a line boundary
   ar_align: assert property (@(posedge clk) disable iff (rst)
      arvalid |-> araddr[`ICACHE_OFFSET_W-1:0] == '0)
      else $error("araddr is not line aligned");

   // decode sees the same instruction while it stalls
   out_hold: assert property (@(posedge clk) disable iff (rst)
      valid && !ready |=> $stable(pc) && $stable(inst))
      else $error("pc or inst changed under back-pressure");

   // first cycle out of reset is quiet with the cache idle
   reset_quiet: assert property (@(posedge clk)
      $fell(rst) |-> !valid && !arvalid && !rready && state == idle)
      else $error("outputs or cache state not idle after reset");

endmodule

bind fetch_unit fetch_unit_asserts asserts_i (
   .clk     (clk),
   .rst     (rst),
   .valid   (valid),
   .ready   (ready),
   .pc      (pc),
   .inst    (inst),
   .araddr  (araddr),
   .arlen   (arlen),
   .arsize  (arsize),
   .arburst (arburst),
   .arvalid (arvalid),
   .arready (arready),
   .rready  (rready),
   .state   (icache_i.state)
);

/* testbench/fetch_unit_tb.sv */
`include "fetch_config.svh"

module fetch_unit_tb import fetch_pkg::*; ();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int clk_period = 100;
   localparam int n_straight = 16;
   localparam int n_run      = 200;
   // transfers over all tests, sizes the watchdog
   localparam int n_total    = n_straight + 3 * n_run + 2;

   // dut inputs start out quiet, reset held
   logic        clk = 1'b0;
   logic        rst = 1'b1;
   logic        ready = 1'b0;
   logic        redirect = 1'b0;
   addr_t       redirect_pc = '0;
   logic        inv_en = 1'b0;
   addr_t       inv_addr = '0;
   logic        arready = 1'b0;
   beat_t       rdata = '0;
   logic [1:0]  rresp = 2'b00;
   logic        rlast = 1'b0;
   logic        rvalid = 1'b0;
   logic        valid;
   logic        arvalid;
   logic        rready;
   addr_t       pc;
   inst_t       inst;
   logic [31:0] araddr;
   logic [7:0]  arlen;
   logic [2:0]  arsize;
   logic [1:0]  arburst;

   // memory model, 4 KiB of words indexed by the low address bits
   inst_t       mem [1024];
   logic [31:0] rng_state = 32'h0176_09b3;
   logic        in_burst = 1'b0;
   logic [31:0] burst_addr = '0;
   int          beat_idx = 0;
   logic        ar_fire = 1'b0;
   logic        r_fire = 1'b0;
   logic        refill_busy = 1'b0;

   // fetch model state
   addr_t       exp_pc = `FETCH_RESET_PC;
   logic        got_transfer = 1'b0;
   addr_t       last_pc = '0;
   inst_t       last_inst = '0;
   int          transfers = 0;
   int          checks = 0;
   int          errors = 0;
   int          test_errors = 0;

   fetch_unit dut_i (.*);

   always #(clk_period / 2) clk = ~clk;

   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   // next pc by the static rule, immediates from the rv64 j and b formats
   function automatic addr_t predict_next(input addr_t at, input inst_t w);
      addr_t imm_j;
      addr_t imm_b;
      imm_j = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      imm_b = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      if (w[6:0] == 7'b1101111) begin
         return at + imm_j;
      end else if (w[6:0] == 7'b1100011 && w[31]) begin
         return at + imm_b;
      end
      return at + 64'd4;
   endfunction

   task automatic report_error(input string msg);
      $display("ERROR %0t: %s", $time, msg);
      errors++;
   endtask

   task automatic end_test(input int num, input string name);
      $display("test %0d %s done, %0d errors", num, name, errors - test_errors);
      test_errors = errors;
   endtask

   // memory side of the axi read, random arready and rvalid gaps
   task automatic drive_memory();
      logic [31:0] r;
      logic [9:0]  w;
      r = next_rand();
      if (ar_fire) begin
         in_burst = 1'b1;
         beat_idx = 0;
      end
      if (r_fire) begin
         // rlast still shows the beat just taken
         if (rlast) begin
            in_burst = 1'b0;
         end
         beat_idx++;
      end
      arready = !in_burst && r[0];
      rvalid  = in_burst && (r[2:1] != 2'b00);
      // lower address in the low half of the beat
      w       = burst_addr[11:2] + 10'(beat_idx * 2);
      rdata   = {mem[w + 10'd1], mem[w]};
      rlast   = rvalid && (beat_idx == `ICACHE_BEATS - 1);
   endtask

   // runs mid cycle, outputs are settled by now
   task automatic sample_outputs();
      ar_fire      = arvalid && arready;
      r_fire       = rvalid && rready;
      refill_busy  = rready;
      got_transfer = 1'b0;
      if (ar_fire) begin
         burst_addr = araddr;
      end
      if (redirect && valid) begin
         report_error("valid high in a redirect cycle");
      end
      if (valid && ready) begin
         got_transfer = 1'b1;
         last_pc      = pc;
         last_inst    = inst;
         transfers++;
         checks += 2;
         if (pc !== exp_pc) begin
            report_error($sformatf("pc %h, expected %h", pc, exp_pc));
         end
         if (inst !== mem[exp_pc[11:2]]) begin
            report_error($sformatf("inst %h, expected %h", inst, mem[exp_pc[11:2]]));
         end
         exp_pc = predict_next(exp_pc, mem[exp_pc[11:2]]);
      end
      // the redirect target is the next pc decode must see
      if (redirect) begin
         exp_pc = redirect_pc;
      end
   endtask

   task automatic step(input logic rdy, input logic redir, input addr_t rpc,
                       input logic inv, input addr_t iaddr);
      @(posedge clk);
      #1;
      drive_memory();
      ready       = rdy;
      redirect    = redir;
      redirect_pc = rpc;
      inv_en      = inv;
      inv_addr    = iaddr;
      @(negedge clk);
      sample_outputs();
   endtask

   task automatic run_transfers(input int n, input logic rand_ready, input logic rand_redir);
      logic [31:0] r;
      logic        rdy;
      logic        redir;
      int          done;
      done = 0;
      while (done < n) begin
         r     = next_rand();
         rdy   = rand_ready ? r[0] : 1'b1;
         // redirects are more likely while a refill runs
         redir = rand_redir && (refill_busy ? (r[4:2] == 3'd0) : (r[8:5] == 4'd0));
         step(rdy, redir, `FETCH_RESET_PC + {52'd0, r[19:10], 2'b00}, 1'b0, '0);
         if (got_transfer) begin
            done++;
         end
      end
   endtask

   initial begin
      logic [31:0] r;
      addr_t       inv_pc;
      inst_t       new_word;
      // random program, about a quarter jal and a quarter branches
      // the first words stay free of jumps for the straight line test
      for (int i = 0; i < 1024; i++) begin
         r = next_rand();
         if (i >= n_straight && r[1:0] == 2'd0) begin
            mem[i] = {r[31:22], 1'b0, r[20:7], 7'b1101111};
         end else if (i >= n_straight && r[1:0] == 2'd1) begin
            mem[i] = {r[31:9], 1'b0, r[7], 7'b1100011};
         end else begin
            mem[i] = {r[31:7], 7'b0010011};
         end
      end
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;

      for (int i = 0; i < n_straight; i++) begin
         run_transfers(1, 1'b0, 1'b0);
         checks++;
         if (last_pc !== `FETCH_RESET_PC + 64'(4 * i)) begin
            report_error($sformatf("straight line pc %h at step %0d", last_pc, i));
         end
      end
      end_test(1, "straight line");
      run_transfers(n_run, 1'b0, 1'b0);
      end_test(2, "prediction");
      run_transfers(n_run, 1'b1, 1'b0);
      end_test(3, "back-pressure");
      run_transfers(n_run, 1'b1, 1'b1);
      end_test(4, "redirect");

      // jump free words, one fetch brings the line in
      inv_pc = `FETCH_RESET_PC + 64'h20;
      step(1'b0, 1'b1, inv_pc, 1'b0, '0);
      run_transfers(1, 1'b0, 1'b0);
      r        = next_rand();
      new_word = {r[31:7], 7'b0010011};
      // store to the cached word, the snoop drops the line
      mem[inv_pc[11:2]] = new_word;
      step(1'b0, 1'b0, '0, 1'b1, inv_pc);
      step(1'b0, 1'b1, inv_pc, 1'b0, '0);
      run_transfers(1, 1'b0, 1'b0);
      checks++;
      if (last_pc !== inv_pc || last_inst !== new_word) begin
         report_error($sformatf("after snoop inst %h, expected %h", last_inst, new_word));
      end
      end_test(5, "invalidation");

      $display("transfers %0d, checks %0d, errors %0d", transfers, checks, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

   // generous bound of 200 cycles per transfer
   initial begin
      #((n_total * 200 + 8) * clk_period);
      $display("timeout: the watchdog stopped the run before all transfers were seen");
      $display("Result: FAILED");
      $finish;
   end

endmodule

/* fetch_unit.f */
+incdir+include
verilog/fetch_pkg.sv
verilog/branch_predictor.sv
verilog/pc_gen.sv
verilog/icache.sv
verilog/fetch_unit.sv
testbench/fetch_unit_asserts.sv
testbench/fetch_unit_tb.sv

/* Makefile */
TOP = fetch_unit_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f fetch_unit.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f fetch_unit.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
